// File: verilog/fp_format_pkg.sv
// fp format package, ieee single precision field layout and widths
package fp_format_pkg;

  // raw operand or result word
  typedef logic [31:0] fp_word_t;

  // biased exponent field
  typedef logic [7:0] exp_t;

  // stored fraction, hidden one not included
  typedef logic [22:0] frac_t;

  // significand with the hidden one prepended
  typedef logic [23:0] sig_t;

  // full significand product
  typedef logic [47:0] prod_t;

  // leading one, 23 fraction bits, guard, round, sticky
  typedef logic [26:0] norm_sig_t;

  typedef struct packed {
    logic  sign;
    exp_t  exp;
    frac_t frac;
  } fp_fields_t;

  localparam int exp_bias  = 127;
  localparam int sig_width = 24; // significand incl. hidden one

endpackage

// File: verilog/fpm_ctrl_pkg.sv
// fpm control package, rounding modes and result flag groups
package fpm_ctrl_pkg;

  // rounding mode encoding, codes above rmm act as rmm
  typedef enum logic [2:0] {
    rne = 3'd0, // nearest, ties to even
    rtz = 3'd1, // toward zero
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4  // nearest, ties away from zero
  } round_mode_e;

  // special case classes, listed in override priority
  typedef struct packed {
    logic nan;
    logic inf;
    logic zer;
  } exc_flags_t;

  // exponent range flags, driven out of the top level
  typedef struct packed {
    logic ovrf;
    logic udrf;
  } range_flags_t;

endpackage

// File: verilog/booth_multiple_gen.sv
// booth multiple generator, forms 1y 2y 3y 4y of the multiplicand significand
module booth_multiple_gen #(
  parameter int sig_width = 24
) (
  input  logic [sig_width-1:0] sig_y,
  output logic [sig_width+2:0] mult_1y,
  output logic [sig_width+2:0] mult_2y,
  output logic [sig_width+2:0] mult_3y,
  output logic [sig_width+2:0] mult_4y
);

  // room for 4y plus a clear top bit, so negation in the digit stays signed
  logic [sig_width+2:0] y_ext;

  assign y_ext = {3'b000, sig_y};

  // even multiples are plain shifts
  assign mult_1y = y_ext;
  assign mult_2y = y_ext << 1;
  assign mult_4y = y_ext << 2;

  // 3y is the hard multiple, one real carry chain
  assign mult_3y = mult_2y + y_ext;

endmodule

// File: verilog/booth_digit.sv
// booth digit, picks one signed radix-8 partial product from a 4-bit multiplier group
module booth_digit #(
  parameter int sig_width = 24
) (
  input  logic [3:0]           group, // {x[3i+2], x[3i+1], x[3i], x[3i-1]}
  input  logic [sig_width+2:0] mult_1y,
  input  logic [sig_width+2:0] mult_2y,
  input  logic [sig_width+2:0] mult_3y,
  input  logic [sig_width+2:0] mult_4y,
  output logic [sig_width+2:0] pp,
  output logic                 neg
);

  logic [2:0]           digit_mag; // 0 to 4
  logic [sig_width+2:0] mag_sel;

  // digit value is -4*g3 + 2*g2 + g1 + g0
  always_comb begin
    case (group)
      4'b0001, 4'b0010, 4'b1101, 4'b1110: digit_mag = 3'd1;
      4'b0011, 4'b0100, 4'b1011, 4'b1100: digit_mag = 3'd2;
      4'b0101, 4'b0110, 4'b1001, 4'b1010: digit_mag = 3'd3;
      4'b0111, 4'b1000:                   digit_mag = 3'd4;
      default:                            digit_mag = 3'd0;
    endcase
  end

  always_comb begin
    case (digit_mag)
      3'd1:    mag_sel = mult_1y;
      3'd2:    mag_sel = mult_2y;
      3'd3:    mag_sel = mult_3y;
      3'd4:    mag_sel = mult_4y;
      default: mag_sel = '0;
    endcase
  end

  // 1111 is a zero digit, kept positive
  assign neg = group[3] & ~(&group[2:0]);

  // one's complement here, the +1 is added by the accumulator
  assign pp = neg ? ~mag_sel : mag_sel;

endmodule

// File: verilog/pp_accumulate.sv
// partial product accumulator, sign-extends, shifts and sums the booth terms
module pp_accumulate
  import fp_format_pkg::*;
#(
  parameter int  sig_width = 24,
  localparam int digits    = sig_width / 3 + 1
) (
  input  logic [sig_width+2:0] pp_bus [digits],
  input  logic [digits-1:0]    neg_bus,
  output prod_t                product
);

  localparam int pp_w   = sig_width + 3;
  localparam int prod_w = $bits(prod_t);

  prod_t pp_ext;
  prod_t neg_ext;

  // each digit weighs 8^i, the sum wraps at 2^48
  always_comb begin
    product = '0;
    pp_ext  = '0;
    neg_ext = '0;
    for (int i = 0; i < digits; i++) begin
      pp_ext  = {{(prod_w - pp_w){pp_bus[i][pp_w-1]}}, pp_bus[i]};
      neg_ext = prod_t'(neg_bus[i]); // two's complement correction
      product = product + (pp_ext << (3 * i)) + (neg_ext << (3 * i));
    end
  end

endmodule

// File: verilog/sig_multiplier.sv
// significand multiplier, radix-8 booth digits summed into the full product
module sig_multiplier
  import fp_format_pkg::*;
#(
  parameter int sig_width = 24
) (
  input  logic [sig_width-1:0] sig_x,
  input  logic [sig_width-1:0] sig_y,
  output prod_t                product
);

  localparam int digits = sig_width / 3 + 1; // enough to cover the unsigned msb
  localparam int pp_w   = sig_width + 3;

  logic [3*digits:0]   x_ext; // bit 0 is the implicit x[-1]
  logic [pp_w-1:0]     mult_1y, mult_2y, mult_3y, mult_4y;
  logic [pp_w-1:0]     pp_bus [digits];
  logic [digits-1:0]   neg_bus;

  assign x_ext = {{(3 * digits - sig_width){1'b0}}, sig_x, 1'b0};

  booth_multiple_gen #(.sig_width(sig_width)) booth_multiple_gen_inst (
    .sig_y   (sig_y),
    .mult_1y (mult_1y),
    .mult_2y (mult_2y),
    .mult_3y (mult_3y),
    .mult_4y (mult_4y)
  );

  for (genvar i = 0; i < digits; i++) begin : g_digit
    booth_digit #(.sig_width(sig_width)) booth_digit_inst (
      .group   (x_ext[3*i+3 -: 4]), // groups overlap by one bit
      .mult_1y (mult_1y),
      .mult_2y (mult_2y),
      .mult_3y (mult_3y),
      .mult_4y (mult_4y),
      .pp      (pp_bus[i]),
      .neg     (neg_bus[i])
    );
  end

  pp_accumulate #(.sig_width(sig_width)) pp_accumulate_inst (
    .pp_bus  (pp_bus),
    .neg_bus (neg_bus),
    .product (product)
  );

endmodule

// File: verilog/norm_round.sv
// normalize and round, one-bit product normalization then rounding by mode
module norm_round
  import fp_format_pkg::*, fpm_ctrl_pkg::*;
(
  input  prod_t       product,
  input  logic        sign_z,
  input  round_mode_e r_mode,
  output frac_t       frac_z,
  output logic        renorm
);

  prod_t       shifted;
  norm_sig_t   norm_sig;
  sig_t        trunc_sig;
  logic        guard;
  logic        round_bit;
  logic        sticky;
  logic [24:0] sig_keep;
  logic [24:0] sig_plus;
  logic [24:0] rounded;

  // product of two [1,2) values lies in [1,4)
  assign shifted = product[47] ? product : product << 1;

  assign norm_sig = {shifted[47:22], |shifted[21:0]};

  assign trunc_sig = norm_sig[26:3];
  assign guard     = norm_sig[2];
  assign round_bit = norm_sig[1];
  assign sticky    = norm_sig[0];

  assign sig_keep = {1'b0, trunc_sig};
  assign sig_plus = trunc_sig + 1'b1; // carry lands in bit 24

  always_comb begin
    case (r_mode)
      rne: begin
        // exact tie goes to the even neighbour
        if (guard && (round_bit || sticky || trunc_sig[0])) begin
          rounded = sig_plus;
        end else begin
          rounded = sig_keep;
        end
      end
      rtz: rounded = sig_keep;
      rdn: rounded = sign_z ? sig_plus : sig_keep; // magnitude grows when negative
      rup: rounded = sign_z ? sig_keep : sig_plus;
      default: begin
        // rmm, codes 5 to 7 land here too
        rounded = guard ? sig_plus : sig_keep;
      end
    endcase
  end

  // a carry out means exactly 2.0, only bit 24 set
  assign frac_z = rounded[22:0];

  assign renorm = product[47] | rounded[24];

endmodule

// File: verilog/exp_exc_pack.sv
// exponent, exception and result packing stage with the output register
module exp_exc_pack
  import fp_format_pkg::*, fpm_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  fp_fields_t   op_x,
  input  fp_fields_t   op_y,
  input  frac_t        frac_z,
  input  logic         renorm,
  output fp_word_t     fp_z,
  output range_flags_t range
);

  localparam fp_word_t qnan_word = 32'h7FC0_0000; // always positive quiet nan

  logic [8:0]   exp_sum;
  logic [8:0]   bias;
  exp_t         exp_z;
  logic         sign_z;
  logic         x_nan, y_nan, x_inf, y_inf, x_zer, y_zer;
  logic         x_max, y_max;
  range_flags_t range_next;
  exc_flags_t   exc;
  fp_fields_t   result;

  assign exp_sum = op_x.exp + op_y.exp;
  assign bias    = renorm ? 9'(exp_bias - 1) : 9'(exp_bias);

  // range check uses exponent fields only
  assign range_next.ovrf = exp_sum >= (9'd255 + bias);
  assign range_next.udrf = exp_sum <= bias;

  assign exp_z  = exp_t'(exp_sum - bias);
  assign sign_z = op_x.sign ^ op_y.sign;

  assign x_max = &op_x.exp;
  assign y_max = &op_y.exp;
  assign x_zer = ~|op_x.exp; // no subnormals, zero exponent is zero
  assign y_zer = ~|op_y.exp;

  assign x_nan = x_max & (|op_x.frac);
  assign y_nan = y_max & (|op_y.frac);
  assign x_inf = x_max & ~(|op_x.frac);
  assign y_inf = y_max & ~(|op_y.frac);

  // inf times zero is invalid
  assign exc.nan = x_nan | y_nan | (x_max & y_zer) | (y_max & x_zer);
  assign exc.inf = x_inf | y_inf | range_next.ovrf;
  assign exc.zer = x_zer | y_zer | range_next.udrf;

  always_comb begin
    result.sign = sign_z;
    result.exp  = exp_z;
    result.frac = frac_z;
    if (exc.nan) begin
      result = qnan_word;
    end else if (exc.inf) begin
      result.exp  = '1;
      result.frac = '0;
    end else if (exc.zer) begin
      result.exp  = '0;
      result.frac = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fp_z  <= '0;
      range <= '0;
    end else begin
      fp_z  <= fp_word_t'(result);
      range <= range_next;
    end
  end

endmodule

// File: verilog/fp_mul_top.sv
// fp multiplier top, single precision multiply with a registered result
module fp_mul_top
  import fp_format_pkg::*, fpm_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  round_mode_e r_mode,
  input  fp_word_t    fp_x,
  input  fp_word_t    fp_y,
  output fp_word_t    fp_z,
  output logic        ovrf,
  output logic        udrf
);

  fp_fields_t   op_x, op_y;
  sig_t         sig_x, sig_y;
  prod_t        product;
  frac_t        frac_z;
  logic         renorm;
  logic         sign_z;
  range_flags_t range;

  assign op_x = fp_x;
  assign op_y = fp_y;

  assign sig_x  = {1'b1, op_x.frac}; // hidden one
  assign sig_y  = {1'b1, op_y.frac};
  assign sign_z = op_x.sign ^ op_y.sign;

  sig_multiplier #(.sig_width(sig_width)) sig_multiplier_inst (
    .sig_x   (sig_x),
    .sig_y   (sig_y),
    .product (product)
  );

  norm_round norm_round_inst (
    .product (product),
    .sign_z  (sign_z),
    .r_mode  (r_mode),
    .frac_z  (frac_z),
    .renorm  (renorm)
  );

  exp_exc_pack exp_exc_pack_inst (
    .clk    (clk),
    .reset  (reset),
    .op_x   (op_x),
    .op_y   (op_y),
    .frac_z (frac_z),
    .renorm (renorm),
    .fp_z   (fp_z),
    .range  (range)
  );

  assign ovrf = range.ovrf;
  assign udrf = range.udrf;

endmodule

// File: testbench/fpm_tb_clock.sv
// testbench clock source, free running square wave with a fixed period
module fpm_tb_clock #(
  parameter int period = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period / 2) clk = ~clk; // 50 percent duty

endmodule

// File: testbench/fpm_tb_tests.svh
// directed tests for the fp multiplier, included into the testbench top
`ifndef fpm_tb_tests_svh
`define fpm_tb_tests_svh

task automatic check_reset_values();
  compare_value("fp_z after reset", fp_z, 32'h0);
  compare_value("ovrf after reset", 32'(ovrf), 32'h0);
  compare_value("udrf after reset", 32'(udrf), 32'h0);
endtask

// back to back normal operands, exponents kept clear of both limits
task automatic random_rne_ops();
  fp_word_t x;
  fp_word_t y;
  for (int i = 0; i < n_random; i++) begin
    x = pack_fields(1'($urandom), 8'($urandom_range(190, 64)), 23'($urandom));
    y = pack_fields(1'($urandom), 8'($urandom_range(190, 64)), 23'($urandom));
    run_op(x, y, 3'd0);
  end
  flush_pending();
endtask

task automatic round_pair(input fp_word_t x, input fp_word_t y);
  fp_word_t   xs;
  logic [2:0] mode;
  logic [2:0] ref_mode;
  for (int s = 0; s < 2; s++) begin
    xs = x ^ (fp_word_t'(s) << 31);
    for (int m = 0; m < n_modes; m++) begin
      mode = (m == n_modes - 1) ? 3'd6 : 3'(m);
      ref_mode = (mode > 3'd4) ? 3'd4 : mode; // spare codes follow rmm
      issue(xs, y, mode, model_mul(xs, y, ref_mode));
    end
  end
endtask

task automatic rounding_modes();
  round_pair(32'h3F80_0001, 32'h3FC0_0000); // exact tie, odd lsb
  round_pair(32'h3F80_0003, 32'h3FC0_0000); // exact tie, even lsb
  round_pair(32'h3FA1_E58F, 32'h3FCA_6691); // product 2^47-1, rounds up to 2.0
  round_pair(32'h3FAA_AAAB, 32'h4040_0000);
  round_pair(32'h3F9D_F3B6, 32'h4049_0FDB);
  round_pair(32'h3FFF_FFFF, 32'h3FFF_FFFF); // just under 4
  flush_pending();
endtask

// result word fixed by the special-case rules, flags from the model
task automatic special_op(input fp_word_t x, input fp_word_t y, input fp_word_t want_z);
  expect_t want;
  want = model_mul(x, y, 3'd0);
  want.z = want_z;
  issue(x, y, 3'd0, want);
endtask

task automatic special_operands();
  special_op(32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000);
  special_op(32'h3F80_0000, 32'h7F80_0001, 32'h7FC0_0000);
  special_op(32'hFFC0_0000, 32'hBF80_0000, 32'h7FC0_0000); // nan sign dropped
  special_op(32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000);
  special_op(32'h8000_0000, 32'hFF80_0000, 32'h7FC0_0000);
  special_op(32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000);
  special_op(32'hFF80_0000, 32'hFF80_0000, 32'h7F80_0000);
  special_op(32'h3F80_0000, 32'hFF80_0000, 32'hFF80_0000);
  special_op(32'h8000_0000, 32'h4040_0000, 32'h8000_0000);
  special_op(32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
  special_op(32'h0000_0001, 32'hBF80_0000, 32'h8000_0000); // zero exponent means zero
  special_op(32'h7FC0_0000, 32'h0000_0000, 32'h7FC0_0000);
  special_op(32'h7F80_0000, 32'h7FC0_0000, 32'h7FC0_0000);
  flush_pending();
endtask

task automatic range_op(input fp_word_t x, input fp_word_t y, input fp_word_t want_z,
                        input logic want_ovrf, input logic want_udrf);
  expect_t want;
  want.z = want_z;
  want.ovrf = want_ovrf;
  want.udrf = want_udrf;
  issue(x, y, 3'd0, want);
endtask

// 1.0 operands keep bias 127, 1.5 operands renormalize to bias 126
task automatic range_limits();
  range_op(pack_fields(0, 254, 0), pack_fields(0, 128, 0), 32'h7F80_0000, 1, 0);
  range_op(pack_fields(0, 254, 0), pack_fields(0, 127, 0), 32'h7F00_0000, 0, 0);
  range_op(pack_fields(1, 200, 0), pack_fields(0, 182, 0), 32'hFF80_0000, 1, 0);
  range_op(pack_fields(1, 200, 0), pack_fields(0, 181, 0), 32'hFF00_0000, 0, 0);
  range_op(pack_fields(0, 254, 23'h40_0000), pack_fields(0, 127, 23'h40_0000),
           32'h7F80_0000, 1, 0);
  range_op(pack_fields(0, 254, 23'h40_0000), pack_fields(0, 126, 23'h40_0000),
           32'h7F10_0000, 0, 0);
  range_op(pack_fields(0, 64, 0), pack_fields(0, 63, 0), 32'h0000_0000, 0, 1);
  range_op(pack_fields(0, 64, 0), pack_fields(0, 64, 0), 32'h0080_0000, 0, 0);
  range_op(pack_fields(1, 63, 23'h40_0000), pack_fields(0, 63, 23'h40_0000),
           32'h8000_0000, 0, 1);
  range_op(pack_fields(1, 63, 23'h40_0000), pack_fields(0, 64, 23'h40_0000),
           32'h8090_0000, 0, 0);
  range_op(pack_fields(0, 1, 0), pack_fields(0, 1, 0), 32'h0000_0000, 0, 1);
  range_op(pack_fields(0, 254, 23'h7F_FFFF), pack_fields(0, 254, 23'h7F_FFFF),
           32'h7F80_0000, 1, 0);
  flush_pending();
endtask

`endif

// File: testbench/fpm_tb.sv
// fp multiplier testbench, drives the top level and checks against a rule model
module fpm_tb
  import fp_format_pkg::*, fpm_ctrl_pkg::*;
();

  localparam int clk_period   = 8;
  localparam int reset_cycles = 5;
  localparam int seed         = 54757;

  // operation counts of the directed tests, used for the watchdog limit
  localparam int n_random      = 200;
  localparam int n_round_pairs = 6;
  localparam int n_modes       = 6;
  localparam int n_special     = 13;
  localparam int n_range       = 12;
  localparam int total_ops     = n_random + n_round_pairs * 2 * n_modes + n_special + n_range;
  localparam int timeout_time  = (total_ops + reset_cycles + 32) * clk_period;

  typedef struct packed {
    fp_word_t z;
    logic     ovrf;
    logic     udrf;
  } expect_t;

  // one issued operation waiting for its result
  typedef struct packed {
    fp_word_t   x;
    fp_word_t   y;
    logic [2:0] mode;
    expect_t    want;
  } op_rec_t;

  logic        clk;
  logic        reset;
  round_mode_e r_mode;
  fp_word_t    fp_x;
  fp_word_t    fp_y;
  fp_word_t    fp_z;
  logic        ovrf;
  logic        udrf;
  op_rec_t     pend;
  logic        pending;

  fpm_tb_clock #(.period(clk_period)) clock_inst (
    .clk (clk)
  );

  fp_mul_top fp_mul_top_inst (
    .clk    (clk),
    .reset  (reset),
    .r_mode (r_mode),
    .fp_x   (fp_x),
    .fp_y   (fp_y),
    .fp_z   (fp_z),
    .ovrf   (ovrf),
    .udrf   (udrf)
  );

  function automatic fp_word_t pack_fields(input logic sign, input exp_t exp, input frac_t frac);
    return {sign, exp, frac};
  endfunction

  // expected result from the format, rounding and range rules
  function automatic expect_t model_mul(input fp_word_t x, input fp_word_t y,
                                        input logic [2:0] mode);
    fp_fields_t  fx;
    fp_fields_t  fy;
    prod_t       p;
    prod_t       n;
    logic [24:0] rnd;
    logic        g, r, s, inc, sgn, carry, renorm;
    logic        is_nan, is_inf, is_zero;
    int          esum;
    int          bias;
    expect_t     e;
    fx = x;
    fy = y;
    sgn = fx.sign ^ fy.sign;
    p = prod_t'({1'b1, fx.frac}) * prod_t'({1'b1, fy.frac});
    n = p[47] ? p : p << 1; // leading one now at bit 47
    g = n[23];
    r = n[22];
    s = |n[21:0];
    case (mode)
      3'd0:    inc = g & (r | s | n[24]);
      3'd1:    inc = 1'b0;
      3'd2:    inc = sgn; // directed modes ignore guard and sticky
      3'd3:    inc = ~sgn;
      default: inc = g;
    endcase
    rnd = {1'b0, n[47:24]} + 25'(inc);
    carry = rnd[24];
    renorm = p[47] | carry;
    bias = renorm ? exp_bias - 1 : exp_bias;
    esum = int'(fx.exp) + int'(fy.exp);
    e.ovrf = (esum >= 255 + bias);
    e.udrf = (esum <= bias);
    is_nan = (fx.exp == 8'hFF && fx.frac != 0) || (fy.exp == 8'hFF && fy.frac != 0) ||
             (fx.exp == 8'hFF && fy.exp == 0) || (fy.exp == 8'hFF && fx.exp == 0);
    is_inf = (fx.exp == 8'hFF) || (fy.exp == 8'hFF) || e.ovrf;
    is_zero = (fx.exp == 0) || (fy.exp == 0) || e.udrf;
    if (is_nan) begin
      e.z = 32'h7FC0_0000;
    end else if (is_inf) begin
      e.z = {sgn, 8'hFF, 23'h0};
    end else if (is_zero) begin
      e.z = {sgn, 31'h0};
    end else begin
      e.z = {sgn, 8'(esum - bias), carry ? 23'h0 : rnd[22:0]}; // carry gives exactly 2.0
    end
    return e;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
      $display("Checks failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_pending();
    string ctx;
    if (pending) begin
      ctx = $sformatf(" for %08h * %08h mode %0d", pend.x, pend.y, pend.mode);
      compare_value({"fp_z", ctx}, fp_z, pend.want.z);
      compare_value({"ovrf", ctx}, 32'(ovrf), 32'(pend.want.ovrf));
      compare_value({"udrf", ctx}, 32'(udrf), 32'(pend.want.udrf));
      pending = 1'b0;
    end
  endtask

  // falling edge: check the previous result, then drive the next operation
  task automatic issue(input fp_word_t x, input fp_word_t y, input logic [2:0] mode,
                       input expect_t want);
    @(negedge clk);
    check_pending();
    fp_x = x;
    fp_y = y;
    r_mode = round_mode_e'(mode);
    pend = '{x: x, y: y, mode: mode, want: want};
    pending = 1'b1;
  endtask

  task automatic run_op(input fp_word_t x, input fp_word_t y, input logic [2:0] mode);
    issue(x, y, mode, model_mul(x, y, mode));
  endtask

  task automatic flush_pending();
    @(negedge clk);
    check_pending();
  endtask

  `include "fpm_tb_tests.svh"

  initial begin
    #(timeout_time);
    $display("timeout: tests did not finish within %0d time units", timeout_time);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(seed));
    reset = 1'b1;
    fp_x = 32'h0080_0000; // smallest normal squared would load udrf
    fp_y = 32'h0080_0000;
    r_mode = rne;
    pending = 1'b0;
    pend = '0;
    repeat (2) @(negedge clk);
    check_reset_values();
    fp_x = 32'h7F00_0000; // large pair would load ovrf and infinity
    fp_y = 32'h7F00_0000;
    repeat (reset_cycles - 2) @(negedge clk);
    check_reset_values();
    reset = 1'b0;
    random_rne_ops();
    rounding_modes();
    special_operands();
    range_limits();
    $display("All checks passed");
    $finish;
  end

endmodule

// File: list.f
+incdir+testbench
verilog/fp_format_pkg.sv
verilog/fpm_ctrl_pkg.sv
verilog/booth_multiple_gen.sv
verilog/booth_digit.sv
verilog/pp_accumulate.sv
verilog/sig_multiplier.sv
verilog/norm_round.sv
verilog/exp_exc_pack.sv
verilog/fp_mul_top.sv
testbench/fpm_tb_clock.sv
testbench/fpm_tb.sv
